//--- hw/l1_macros.svh
// Cache geometry, address split and credit count macros
`ifndef L1_MACROS_SVH
`define L1_MACROS_SVH

// Address split is tag, then set index, then byte offset
`define L1_ADDR_W      16
`define L1_OFFSET_W    4
`define L1_INDEX_W     4
`define L1_SETS        16
`define L1_TAG_W       8

// Way counts per cache
`define L1_D_WAYS      8
`define L1_I_WAYS      4
`define L1_WAY_W       3
`define L1_AGE_W       3

// Credits on both sides of the controller
`define L1_CMD_DEPTH   4
`define L1_RSP_CREDITS 2

`endif

//--- hw/l1_pkg.sv
// Command, MESI state and per-way state types
`include "l1_macros.svh"

package l1_pkg;

    // Host command codes
    typedef enum logic [1:0] {
        CMD_READ  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_FETCH = 2'd2,
        CMD_INVAL = 2'd3
    } cmd_e;

    // Coherence state of one line
    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } mesi_e;

    // One way of one set, higher age is older
    typedef struct packed {
        logic [`L1_TAG_W-1:0] tag;
        mesi_e                mesi;
        logic [`L1_AGE_W-1:0] age;
    } way_state_t;

endpackage

//--- hw/l1_cmd_fifo.sv
// Command FIFO with credit return on each released entry
`timescale 1ns/1ns
`include "l1_macros.svh"

module l1_cmd_fifo (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   push_i,
    input  l1_pkg::cmd_e           op_i,
    input  logic [`L1_ADDR_W-1:0]  addr_i,
    input  l1_pkg::mesi_e          mesi_i,
    input  logic                   pop_i,
    output logic                   head_valid_o,
    output l1_pkg::cmd_e           head_op_o,
    output logic [`L1_ADDR_W-1:0]  head_addr_o,
    output l1_pkg::mesi_e          head_mesi_o,
    output logic                   credit_o
);
    localparam int DEPTH = `L1_CMD_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // One entry slot per host credit
    l1_pkg::cmd_e          op_mem   [DEPTH];
    logic [`L1_ADDR_W-1:0] addr_mem [DEPTH];
    l1_pkg::mesi_e         mesi_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Payload lands in the slot at the write pointer
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            op_mem[wr_ptr_q]   <= op_i;
            addr_mem[wr_ptr_q] <= addr_i;
            mesi_mem[wr_ptr_q] <= mesi_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Credit goes back to the host one cycle after the pop
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;
        end
    end

    // Head is read straight from the slot array
    assign head_valid_o = (count_q != '0);
    assign head_op_o    = op_mem[rd_ptr_q];
    assign head_addr_o  = addr_mem[rd_ptr_q];
    assign head_mesi_o  = mesi_mem[rd_ptr_q];

endmodule

//--- hw/l1_way_select.sv
// Tag compare, hit way and LRU victim choice over one set
`timescale 1ns/1ns
`include "l1_macros.svh"

module l1_way_select #(
    parameter int WAYS = 4
) (
    input  logic [`L1_TAG_W-1:0] tag_i,
    input  l1_pkg::way_state_t   ways_i [WAYS],
    output logic                 hit_o,
    output logic [`L1_WAY_W-1:0] way_o
);
    localparam int WAY_W = `L1_WAY_W;

    logic [WAYS-1:0]      match;
    logic [WAY_W-1:0]     hit_way;
    logic                 found_inval;
    logic [WAY_W-1:0]     inval_way;
    logic [`L1_AGE_W-1:0] inval_age;
    logic [WAY_W-1:0]     old_way;
    logic [`L1_AGE_W-1:0] old_age;

    // A way hits only when its tag matches and it holds a valid line
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = (ways_i[w].tag == tag_i) && (ways_i[w].mesi != l1_pkg::MESI_I);
        end
    end

    // Lowest matching way, scanned from the top so the last hit wins
    always_comb begin
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    // Victim search, strict compare keeps ties on the lower index
    always_comb begin
        found_inval = 1'b0;
        inval_way   = '0;
        inval_age   = '0;
        old_way     = '0;
        old_age     = ways_i[0].age;
        for (int w = 0; w < WAYS; w++) begin
            if (ways_i[w].age > old_age) begin
                old_way = WAY_W'(w);
                old_age = ways_i[w].age;
            end
            // Invalid ways are preferred over any valid one
            if (ways_i[w].mesi == l1_pkg::MESI_I) begin
                if (!found_inval || (ways_i[w].age > inval_age)) begin
                    found_inval = 1'b1;
                    inval_way   = WAY_W'(w);
                    inval_age   = ways_i[w].age;
                end
            end
        end
    end

    assign hit_o = |match;

    // Hit way first, then oldest invalid, then oldest overall
    always_comb begin
        if (hit_o) begin
            way_o = hit_way;
        end else if (found_inval) begin
            way_o = inval_way;
        end else begin
            way_o = old_way;
        end
    end

endmodule

//--- hw/l1_set_store.sv
// Per-cache tag, MESI and age arrays with true LRU aging
`timescale 1ns/1ns
`include "l1_macros.svh"

module l1_set_store #(
    parameter int WAYS = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`L1_INDEX_W-1:0] index_i,
    output l1_pkg::way_state_t     ways_o [WAYS],
    input  logic                   wr_i,
    input  logic [`L1_WAY_W-1:0]   wr_way_i,
    input  logic [`L1_TAG_W-1:0]   wr_tag_i,
    input  l1_pkg::mesi_e          wr_mesi_i,
    input  logic                   age_i
);
    localparam int SETS  = `L1_SETS;
    localparam int AGE_W = `L1_AGE_W;
    localparam int IDX_W = $clog2(WAYS);

    // State of every way in every set
    l1_pkg::way_state_t sets_q [SETS][WAYS];

    logic [IDX_W-1:0] wr_idx;
    logic [AGE_W-1:0] wr_age;

    // Only the low bits address a way in the smaller cache
    assign wr_idx = wr_way_i[IDX_W-1:0];

    // Age of the written way before this access
    assign wr_age = sets_q[index_i][wr_idx].age;

    // Read port is combinational on the set index
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            ways_o[w] = sets_q[index_i][w];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // All ways empty, ages start as a permutation equal to the way number
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    sets_q[s][w].tag  <= '0;
                    sets_q[s][w].mesi <= l1_pkg::MESI_I;
                    sets_q[s][w].age  <= AGE_W'(w);
                end
            end
        end else if (wr_i) begin
            sets_q[index_i][wr_idx].tag  <= wr_tag_i;
            sets_q[index_i][wr_idx].mesi <= wr_mesi_i;
            if (age_i) begin
                // Ways more recent than the touched one slide back by one
                for (int w = 0; w < WAYS; w++) begin
                    if (w == int'(wr_idx)) begin
                        sets_q[index_i][w].age <= '0;
                    end else if (sets_q[index_i][w].age < wr_age) begin
                        sets_q[index_i][w].age <= sets_q[index_i][w].age + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- hw/l1_lookup.sv
// Lookup stage with cache routing, array write-back and response credits
`timescale 1ns/1ns
`include "l1_macros.svh"

module l1_lookup (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  head_valid_i,
    input  l1_pkg::cmd_e          head_op_i,
    input  logic [`L1_ADDR_W-1:0] head_addr_i,
    input  l1_pkg::mesi_e         head_mesi_i,
    output logic                  head_pop_o,
    input  logic                  rsp_credit_i,
    output logic                  rsp_valid_o,
    output logic                  rsp_hit_o,
    output logic [`L1_WAY_W-1:0]  rsp_way_o,
    output logic                  rsp_evict_valid_o,
    output logic [`L1_TAG_W-1:0]  rsp_evict_tag_o,
    output l1_pkg::mesi_e         rsp_evict_mesi_o
);
    localparam int I_IDX_W = $clog2(`L1_I_WAYS);
    localparam int D_IDX_W = $clog2(`L1_D_WAYS);
    localparam int CRED_W  = $clog2(`L1_RSP_CREDITS + 1);

    logic [`L1_TAG_W-1:0]   tag;
    logic [`L1_INDEX_W-1:0] index;
    logic                   is_fetch;
    logic                   is_inval;

    l1_pkg::way_state_t   i_ways [`L1_I_WAYS];
    l1_pkg::way_state_t   d_ways [`L1_D_WAYS];
    logic                 i_hit;
    logic                 d_hit;
    logic [`L1_WAY_W-1:0] i_way;
    logic [`L1_WAY_W-1:0] d_way;

    logic                 sel_hit;
    logic [`L1_WAY_W-1:0] sel_way;
    l1_pkg::way_state_t   victim;
    logic                 i_wr;
    logic                 d_wr;
    logic                 do_age;
    logic [CRED_W-1:0]    credit_q;

    // Byte offset bits are not part of the lookup
    assign tag   = head_addr_i[`L1_ADDR_W-1 -: `L1_TAG_W];
    assign index = head_addr_i[`L1_OFFSET_W +: `L1_INDEX_W];

    // Fetch goes to the I-cache, everything else including invalidate to the D-cache
    assign is_fetch = (head_op_i == l1_pkg::CMD_FETCH);
    assign is_inval = (head_op_i == l1_pkg::CMD_INVAL);

    // A credit returned this cycle can be spent right away
    assign head_pop_o = head_valid_i && ((credit_q != '0) || rsp_credit_i);

    // Invalidate misses leave the arrays alone, invalidate hits skip aging
    assign i_wr   = head_pop_o && is_fetch;
    assign d_wr   = head_pop_o && !is_fetch && !(is_inval && !d_hit);
    assign do_age = !is_inval;

    l1_set_store #(.WAYS(`L1_I_WAYS)) u_i_store (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .index_i   (index),
        .ways_o    (i_ways),
        .wr_i      (i_wr),
        .wr_way_i  (i_way),
        .wr_tag_i  (tag),
        .wr_mesi_i (head_mesi_i),
        .age_i     (do_age)
    );

    l1_set_store #(.WAYS(`L1_D_WAYS)) u_d_store (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .index_i   (index),
        .ways_o    (d_ways),
        .wr_i      (d_wr),
        .wr_way_i  (d_way),
        .wr_tag_i  (tag),
        .wr_mesi_i (head_mesi_i),
        .age_i     (do_age)
    );

    l1_way_select #(.WAYS(`L1_I_WAYS)) u_i_select (
        .tag_i  (tag),
        .ways_i (i_ways),
        .hit_o  (i_hit),
        .way_o  (i_way)
    );

    l1_way_select #(.WAYS(`L1_D_WAYS)) u_d_select (
        .tag_i  (tag),
        .ways_i (d_ways),
        .hit_o  (d_hit),
        .way_o  (d_way)
    );

    // Result of the addressed cache, victim is the old content of the chosen way
    assign sel_hit = is_fetch ? i_hit : d_hit;
    assign sel_way = is_fetch ? i_way : d_way;
    assign victim  = is_fetch ? i_ways[i_way[I_IDX_W-1:0]] : d_ways[d_way[D_IDX_W-1:0]];

    // Control part of the response
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o       <= 1'b0;
            rsp_evict_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= head_pop_o;
            // Nothing is evicted on a hit, on an empty victim or on an invalidate miss
            rsp_evict_valid_o <= head_pop_o && !sel_hit && !is_inval &&
                                 (victim.mesi != l1_pkg::MESI_I);
        end
    end

    // Response payload
    always_ff @(posedge clk_i) begin
        if (head_pop_o) begin
            rsp_hit_o        <= sel_hit;
            rsp_way_o        <= sel_way;
            rsp_evict_tag_o  <= victim.tag;
            rsp_evict_mesi_o <= victim.mesi;
        end
    end

    // Response credits held by the DUT
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credit_q <= CRED_W'(`L1_RSP_CREDITS);
        end else if (head_pop_o && !rsp_credit_i) begin
            credit_q <= credit_q - 1'b1;
        end else if (rsp_credit_i && !head_pop_o) begin
            credit_q <= credit_q + 1'b1;
        end
    end

endmodule

//--- hw/l1_split_cache.sv
// Split L1 tag controller top with command FIFO and lookup stage
`timescale 1ns/1ns
`include "l1_macros.svh"

module l1_split_cache (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  cmd_valid_i,
    input  l1_pkg::cmd_e          cmd_op_i,
    input  logic [`L1_ADDR_W-1:0] cmd_addr_i,
    input  l1_pkg::mesi_e         cmd_mesi_i,
    output logic                  cmd_credit_o,
    output logic                  rsp_valid_o,
    output logic                  rsp_hit_o,
    output logic [`L1_WAY_W-1:0]  rsp_way_o,
    output logic                  rsp_evict_valid_o,
    output logic [`L1_TAG_W-1:0]  rsp_evict_tag_o,
    output l1_pkg::mesi_e         rsp_evict_mesi_o,
    input  logic                  rsp_credit_i
);
    // Head of the queue as seen by the lookup stage
    logic                  head_valid;
    l1_pkg::cmd_e          head_op;
    logic [`L1_ADDR_W-1:0] head_addr;
    l1_pkg::mesi_e         head_mesi;
    logic                  head_pop;

    // Host credits bound the queue, so every valid command is pushed
    l1_cmd_fifo u_cmd_fifo (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (cmd_valid_i),
        .op_i         (cmd_op_i),
        .addr_i       (cmd_addr_i),
        .mesi_i       (cmd_mesi_i),
        .pop_i        (head_pop),
        .head_valid_o (head_valid),
        .head_op_o    (head_op),
        .head_addr_o  (head_addr),
        .head_mesi_o  (head_mesi),
        .credit_o     (cmd_credit_o)
    );

    // One command per cycle at most, gated by response credits
    l1_lookup u_lookup (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .head_valid_i      (head_valid),
        .head_op_i         (head_op),
        .head_addr_i       (head_addr),
        .head_mesi_i       (head_mesi),
        .head_pop_o        (head_pop),
        .rsp_credit_i      (rsp_credit_i),
        .rsp_valid_o       (rsp_valid_o),
        .rsp_hit_o         (rsp_hit_o),
        .rsp_way_o         (rsp_way_o),
        .rsp_evict_valid_o (rsp_evict_valid_o),
        .rsp_evict_tag_o   (rsp_evict_tag_o),
        .rsp_evict_mesi_o  (rsp_evict_mesi_o)
    );

endmodule

//--- tests/tb_clock.sv
// Free-running testbench clock generator
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);
    // Starts low, first rising edge half a period in
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

endmodule

//--- tests/tb_l1_split_cache.sv
// Testbench for the split L1 tag controller with reference model, credit driver and checker
`timescale 1ns/1ns
`include "l1_macros.svh"

module tb_l1_split_cache;
    localparam int TIMEOUT = 600;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  cmd_valid_i;
    l1_pkg::cmd_e          cmd_op_i;
    logic [`L1_ADDR_W-1:0] cmd_addr_i;
    l1_pkg::mesi_e         cmd_mesi_i;
    logic                  cmd_credit_o;
    logic                  rsp_valid_o;
    logic                  rsp_hit_o;
    logic [`L1_WAY_W-1:0]  rsp_way_o;
    logic                  rsp_evict_valid_o;
    logic [`L1_TAG_W-1:0]  rsp_evict_tag_o;
    l1_pkg::mesi_e         rsp_evict_mesi_o;
    logic                  rsp_credit_i;

    // Model of both caches, index 0 is the D-cache and 1 the I-cache
    logic [7:0] m_tag [2][16][8];
    logic [1:0] m_mesi [2][16][8];
    int         m_age [2][16][8];

    // Expected {hit, way, evict valid, evict tag, evict mesi}, in command order
    logic [14:0] exp_q [$];
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;
    int          sent_cnt;
    int          returned_cnt;
    int          rsp_count;
    int          credits_given;
    int          credit_gap;
    logic        hold_credits;
    logic [31:0] rng;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk_o(clk_i));

    l1_split_cache dut0 (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Tag match, victim choice and LRU aging on the model; returns the expected response
    function automatic logic [14:0] ref_access(input l1_pkg::cmd_e op, input logic [15:0] addr,
                                               input l1_pkg::mesi_e mesi);
        int          c;
        int          s;
        int          nw;
        int          v;
        int          old_age;
        logic        hit;
        logic        found;
        logic        inval;
        logic [14:0] rsp;
        c = (op == l1_pkg::CMD_FETCH) ? 1 : 0;
        s = int'(addr[7:4]);
        nw = (c == 1) ? `L1_I_WAYS : `L1_D_WAYS;
        inval = (op == l1_pkg::CMD_INVAL);
        hit = 1'b0;
        found = 1'b0;
        v = 0;
        // Lowest valid way holding the tag
        for (int w = nw - 1; w >= 0; w--) begin
            if (m_tag[c][s][w] == addr[15:8] && m_mesi[c][s][w] != l1_pkg::MESI_I) begin
                hit = 1'b1;
                v = w;
            end
        end
        // Oldest invalid way first, ties stay on the lower index
        for (int w = 0; w < nw && !hit; w++) begin
            if (m_mesi[c][s][w] == l1_pkg::MESI_I && (!found || m_age[c][s][w] > m_age[c][s][v])) begin
                found = 1'b1;
                v = w;
            end
        end
        // Then the oldest way of all
        for (int w = 0; w < nw && !hit && !found; w++) begin
            if (m_age[c][s][w] > m_age[c][s][v]) begin
                v = w;
            end
        end
        rsp = {hit, 3'(v), !hit && !inval && m_mesi[c][s][v] != l1_pkg::MESI_I,
               m_tag[c][s][v], m_mesi[c][s][v]};
        // Invalidate miss changes nothing, invalidate hit keeps the ages
        if (!inval || hit) begin
            old_age = m_age[c][s][v];
            m_tag[c][s][v] = addr[15:8];
            m_mesi[c][s][v] = mesi;
            for (int w = 0; w < nw && !inval; w++) begin
                if (w == v) begin
                    m_age[c][s][w] = 0;
                end else if (m_age[c][s][w] < old_age) begin
                    m_age[c][s][w] = m_age[c][s][w] + 1;
                end
            end
        end
        return rsp;
    endfunction

    task automatic step();
        @(posedge clk_i);
        #5;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout in test %s: %s", cur_test, what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic report_failure(input string what);
        $display("Failure in test %s: %s", cur_test, what);
        test_errs++;
        total_errs++;
    endtask

    task automatic report_mismatch(input string field, input logic [7:0] want,
                                   input logic [7:0] got);
        $display("[ERROR] %s %s expected %0h actual %0h", cur_test, field, want, got);
        test_errs++;
        total_errs++;
    endtask

    // Waits for a command credit, then drives one command for one cycle
    task automatic send_cmd(input l1_pkg::cmd_e op, input logic [15:0] addr,
                            input l1_pkg::mesi_e mesi);
        int waited;
        waited = 0;
        while (sent_cnt - returned_cnt >= `L1_CMD_DEPTH) begin
            step();
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("no command credit came back");
            end
        end
        cmd_valid_i = 1'b1;
        cmd_op_i = op;
        cmd_addr_i = addr;
        cmd_mesi_i = mesi;
        exp_q.push_back(ref_access(op, addr, mesi));
        sent_cnt++;
        step();
        cmd_valid_i = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    // Drains responses and both credit loops, then prints the test line
    task automatic end_test();
        int waited;
        waited = 0;
        while (rsp_count != sent_cnt || returned_cnt != sent_cnt || credits_given != rsp_count) begin
            step();
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("responses or credits did not drain");
            end
        end
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("%-14s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    endtask

    // Response credits go back two cycles apart unless withheld
    always @(posedge clk_i) begin
        #5;
        if (!hold_credits && rsp_count > credits_given && credit_gap >= 2) begin
            rsp_credit_i = 1'b1;
            credits_given++;
            credit_gap = 0;
        end else begin
            rsp_credit_i = 1'b0;
            credit_gap++;
        end
    end

    // Outputs sampled mid-cycle, each response paired with the oldest expectation
    always @(negedge clk_i) begin
        logic [14:0] want;
        if (rst_n_i && cmd_credit_o) begin
            returned_cnt++;
        end
        if (rst_n_i && rsp_valid_o) begin
            rsp_count++;
            if (exp_q.size() == 0) begin
                report_failure("a response arrived with no command outstanding");
            end else begin
                want = exp_q.pop_front();
                if (rsp_hit_o != want[14]) begin
                    report_mismatch("hit", 8'(want[14]), 8'(rsp_hit_o));
                end
                if (rsp_way_o != want[13:11]) begin
                    report_mismatch("way", 8'(want[13:11]), 8'(rsp_way_o));
                end
                if (rsp_evict_valid_o != want[10]) begin
                    report_mismatch("evict_valid", 8'(want[10]), 8'(rsp_evict_valid_o));
                end
                // Evicted tag and state only mean something on an eviction
                if (want[10] && rsp_evict_tag_o != want[9:2]) begin
                    report_mismatch("evict_tag", want[9:2], rsp_evict_tag_o);
                end
                if (want[10] && rsp_evict_mesi_o != want[1:0]) begin
                    report_mismatch("evict_mesi", 8'(want[1:0]), 8'(rsp_evict_mesi_o));
                end
            end
        end
        if (rsp_count > credits_given + `L1_RSP_CREDITS) begin
            report_failure("more responses than response credits allow");
        end
        if (returned_cnt > sent_cnt) begin
            report_failure("a command credit came back for no command");
        end
    end

    initial begin
        l1_pkg::cmd_e  op;
        l1_pkg::mesi_e mesi;
        int            waited;
        cmd_valid_i = 1'b0;
        cmd_op_i = l1_pkg::CMD_READ;
        cmd_addr_i = '0;
        cmd_mesi_i = l1_pkg::MESI_I;
        rsp_credit_i = 1'b0;
        rst_n_i = 1'b0;
        hold_credits = 1'b0;
        {test_errs, total_errs, tests_run, tests_failed} = '0;
        {sent_cnt, returned_cnt, rsp_count, credits_given, credit_gap} = '0;
        rng = 32'hc17d;
        cur_test = "reset";
        // Empty lines, ages equal to the way number
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < 16; s++) begin
                for (int w = 0; w < 8; w++) begin
                    m_tag[c][s][w] = '0;
                    m_mesi[c][s][w] = l1_pkg::MESI_I;
                    m_age[c][s][w] = w;
                end
            end
        end
        repeat (3) @(posedge clk_i);
        #5;
        rst_n_i = 1'b1;
        if (cmd_credit_o || rsp_valid_o || rsp_evict_valid_o) begin
            report_failure("outputs were not low after reset");
        end

        // Eight misses fill set 3 from way 7 down, then one hit
        begin_test("fill_order");
        for (int t = 1; t <= 8; t++) begin
            send_cmd(l1_pkg::CMD_READ, {8'(t), 4'd3, 4'h0}, l1_pkg::MESI_E);
        end
        send_cmd(l1_pkg::CMD_READ, {8'd3, 4'd3, 4'h0}, l1_pkg::MESI_E);
        end_test();

        // Ninth tag evicts the LRU way, fetches fill the I-cache alone
        begin_test("lru_evict");
        send_cmd(l1_pkg::CMD_WRITE, {8'd9, 4'd3, 4'h0}, l1_pkg::MESI_M);
        for (int t = 1; t <= 5; t++) begin
            send_cmd(l1_pkg::CMD_FETCH, {8'(t), 4'd3, 4'h8}, l1_pkg::MESI_S);
        end
        send_cmd(l1_pkg::CMD_READ, {8'd4, 4'd3, 4'h0}, l1_pkg::MESI_S);
        end_test();

        // Freed way is reused next, a miss on invalidate leaves the set alone
        begin_test("invalidate");
        send_cmd(l1_pkg::CMD_INVAL, {8'd5, 4'd3, 4'h0}, l1_pkg::MESI_I);
        send_cmd(l1_pkg::CMD_READ, {8'd10, 4'd3, 4'h0}, l1_pkg::MESI_E);
        send_cmd(l1_pkg::CMD_INVAL, {8'h77, 4'd3, 4'h0}, l1_pkg::MESI_I);
        send_cmd(l1_pkg::CMD_READ, {8'd10, 4'd3, 4'h0}, l1_pkg::MESI_E);
        end_test();

        // Sixteen tags over two sets give both hits and evictions
        begin_test("random_mix");
        for (int n = 0; n < 200; n++) begin
            rng = xorshift(rng);
            op = l1_pkg::cmd_e'(rng[1:0]);
            mesi = l1_pkg::mesi_e'(rng[15:14]);
            if (op != l1_pkg::CMD_INVAL && mesi == l1_pkg::MESI_I) begin
                mesi = l1_pkg::MESI_S;
            end
            send_cmd(op, {4'h0, rng[11:8], 3'b010, rng[12], rng[7:4]}, mesi);
        end
        end_test();

        // Withheld credits let two responses out and fill the queue behind them
        begin_test("backpressure");
        hold_credits = 1'b1;
        for (int n = 0; n < 6; n++) begin
            send_cmd(l1_pkg::CMD_READ, {8'(n + 20), 4'd7, 4'h0}, l1_pkg::MESI_S);
        end
        waited = 0;
        while (rsp_count != credits_given + `L1_RSP_CREDITS) begin
            step();
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("responses within the credit limit never arrived");
            end
        end
        repeat (10) step();
        if (rsp_count != credits_given + `L1_RSP_CREDITS) begin
            report_failure("responses continued without response credits");
        end
        if (sent_cnt - returned_cnt != `L1_CMD_DEPTH) begin
            report_failure("the command queue did not hold a full set of commands");
        end
        hold_credits = 1'b0;
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/l1_pkg.sv
hw/l1_cmd_fifo.sv
hw/l1_way_select.sv
hw/l1_set_store.sv
hw/l1_lookup.sv
hw/l1_split_cache.sv
tests/tb_clock.sv
tests/tb_l1_split_cache.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns -f build.f \
    --top-module tb_l1_split_cache -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && cat sim.log \
    && grep -q "All tests passed!" sim.log \
    && echo "Simulation passed" \
    || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
